// File: intDiv.f
+incdir+src
src/divBusPkg.sv
src/divCorePkg.sv
src/divOperandPrep.sv
src/divStep.sv
src/divIterate.sv
src/divResultFix.sv
src/divHandshake.sv
src/intDivUnit.sv
tb/intDivTb.sv

// File: runSim.sh
#!/bin/sh
# Builds the divider testbench with Verilator and runs it into sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module intDivTb -f intDiv.f --Mdir obj_dir -o intDivSim

# The log decides the outcome, so a nonzero exit of the model is caught below
./obj_dir/intDivSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
  exit 0
fi
exit 1

// File: tb/intDivTb.sv
////////////////////////////////////////
// Integer divider testbench
// Random and corner operands on req/ack
////////////////////////////////////////
`include "intDiv_params.svh"

module intDivTb;

  import divBusPkg::*;

  localparam int DriveDelay         = 10;
  localparam int UnsignedPairs      = 40;
  localparam int SignedPairsPerCase = 5;
  localparam int HandshakeOps       = 8;
  // Each operation gets a slot of the iteration length plus handshake margin, twice over
  localparam int NumOps     = 2 * UnsignedPairs + 8 * SignedPairsPerCase + 4 + 2 + HandshakeOps;
  localparam int CycleLimit = NumOps * (`DIV_STEPS + 6) * 2;

  logic                 clk;
  logic                 reset;
  logic                 req;
  divReq_s              reqData;
  logic                 ack;
  divRsp_s              rspData;
  logic [`DIV_XLEN-1:0] expResult;
  logic [31:0]          lcgState;
  int                   errCount    = 0;
  int                   failedTests = 0;
  int                   opCount     = 0;
  int                   cycleCnt    = 0;
  int                   reqEdges    = 0;

  intDivUnit u_intDivUnit (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .reqData(reqData),
    .ack    (ack),
    .rspData(rspData)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////
  // Reference model and random source
  ////////////////////////////////////////

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Divisor with a random number of leading zeros, never zero and never negative
  function automatic logic [31:0] randMagnitude();
    logic [31:0] m;
    m = nextRand() >> (1 + nextRand() % 31);
    if (m == '0) m = 32'd1;
    return m;
  endfunction

  // RISC-V M-extension results, with zero divisor and overflow taken first
  function automatic logic [`DIV_XLEN-1:0] refResult(divOp_e op, logic [`DIV_XLEN-1:0] a,
                                                     logic [`DIV_XLEN-1:0] b);
    logic signed [`DIV_XLEN-1:0] sa;
    logic signed [`DIV_XLEN-1:0] sb;
    logic                        overflow;
    sa = a;
    sb = b;
    overflow = (a == {1'b1, {(`DIV_XLEN-1){1'b0}}}) && (b == '1);
    refResult = '0;
    case (op)
      opDivu: begin
        if (b == '0) refResult = '1;
        else refResult = a / b;
      end
      opRemu: begin
        if (b == '0) refResult = a;
        else refResult = a % b;
      end
      opDiv: begin
        if (b == '0) refResult = '1;
        else if (overflow) refResult = a;
        else refResult = sa / sb;
      end
      default: begin
        if (b == '0) refResult = a;
        else if (overflow) refResult = '0;
        else refResult = sa % sb;
      end
    endcase
  endfunction

  ////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////

  // Inputs move a fixed delay after the rising edge, away from the sampling point
  task automatic waitClock();
    @(posedge clk);
    #DriveDelay;
  endtask

  // One full four-phase exchange, with ack held for a number of extra cycles
  task automatic runOp(divOp_e op, logic [`DIV_XLEN-1:0] a, logic [`DIV_XLEN-1:0] b,
                       int holdCycles);
    expResult        = refResult(op, a, b);
    reqData.op       = op;
    reqData.dividend = a;
    reqData.divisor  = b;
    req              = 1'b1;
    waitClock();
    while (!ack) waitClock();
    repeat (holdCycles) waitClock();
    req = 1'b0;
    waitClock();
    while (ack) waitClock();
    opCount++;
  endtask

  task automatic reportTest(int num, string name, int errBefore);
    if (errCount == errBefore) begin
      $display("Test %0d %s: ok", num, name);
    end else begin
      failedTests++;
      $display("Test %0d %s: %0d errors", num, name, errCount - errBefore);
    end
  endtask

  task automatic testUnsigned();
    logic [31:0] a;
    logic [31:0] b;
    int          errBefore;
    errBefore = errCount;
    for (int i = 0; i < UnsignedPairs; i++) begin
      a = nextRand();
      // Every fourth divisor uses the full width so that small quotients show up too
      b = (i % 4 == 0) ? (nextRand() | 32'h1) : randMagnitude();
      runOp(opDivu, a, b, 0);
      runOp(opRemu, a, b, 0);
    end
    reportTest(1, "unsigned divide and remainder", errBefore);
  endtask

  task automatic testSigned();
    logic [31:0] a;
    logic [31:0] mag;
    logic [31:0] b;
    int          errBefore;
    errBefore = errCount;
    // Bit 1 of the case picks the dividend sign and bit 0 the divisor sign
    for (int signCase = 0; signCase < 4; signCase++) begin
      for (int i = 0; i < SignedPairsPerCase; i++) begin
        a     = nextRand();
        a[31] = signCase[1];
        mag   = randMagnitude();
        b     = signCase[0] ? -mag : mag;
        runOp(opDiv, a, b, 0);
        runOp(opRem, a, b, 0);
      end
    end
    reportTest(2, "signed divide and remainder", errBefore);
  endtask

  task automatic testDivZero();
    logic [31:0] a;
    int          errBefore;
    errBefore = errCount;
    // Negative dividend so the signed remainder has to be rebuilt from its magnitude
    a = nextRand() | 32'h8000_0000;
    runOp(opDiv, a, '0, 0);
    runOp(opDivu, a, '0, 0);
    runOp(opRem, a, '0, 0);
    runOp(opRemu, a, '0, 0);
    reportTest(3, "division by zero", errBefore);
  endtask

  task automatic testOverflow();
    int errBefore;
    errBefore = errCount;
    runOp(opDiv, 32'h8000_0000, 32'hffff_ffff, 0);
    runOp(opRem, 32'h8000_0000, 32'hffff_ffff, 0);
    reportTest(4, "signed overflow", errBefore);
  endtask

  task automatic testHandshake();
    divOp_e op;
    int     errBefore;
    errBefore = errCount;
    for (int i = 0; i < HandshakeOps; i++) begin
      op = divOp_e'(nextRand() & 32'h3);
      runOp(op, nextRand(), randMagnitude(), nextRand() % 6);
    end
    reportTest(5, "handshake timing", errBefore);
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Edges that saw req high with ack still low, the edge that raises ack included
  always @(posedge clk) begin
    if (reset || !req) begin
      reqEdges <= 0;
    end else if (!ack) begin
      reqEdges <= reqEdges + 1;
    end
  end

  resultMatches: assert property (@(posedge clk) disable iff (reset)
    ack |-> (rspData.result == expResult))
    else begin
      errCount++;
      $display("ERROR rspData.result got %h expected %h", rspData.result, expResult);
    end

  ackLowAfterReset: assert property (@(posedge clk) reset |=> !ack)
    else begin
      errCount++;
      $display("Ack was high right after a reset cycle");
    end

  // Ack rises a fixed number of edges after the one that first sampled req
  ackLatency: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> (reqEdges - 1 == `DIV_STEPS + 3))
    else begin
      errCount++;
      $display("ERROR ack latency got %h expected %h", reqEdges - 1, `DIV_STEPS + 3);
    end

  ackHeldWithReq: assert property (@(posedge clk) disable iff (reset)
    (ack && req) |=> ack)
    else begin
      errCount++;
      $display("Ack dropped while req was still high");
    end

  resultStable: assert property (@(posedge clk) disable iff (reset)
    (ack && $past(ack)) |-> $stable(rspData))
    else begin
      errCount++;
      $display("The response changed while ack was held");
    end

  ackFallsAfterReq: assert property (@(posedge clk) disable iff (reset)
    (ack && !req) |=> !ack)
    else begin
      errCount++;
      $display("Ack stayed high one edge after req fell");
    end

  // The run must finish within the budget worked out from the operation count
  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (cycleCnt >= CycleLimit) begin
      $display("Timeout after %0d cycles, the divider stopped answering", cycleCnt);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    req       = 1'b0;
    reqData   = '0;
    expResult = '0;
    lcgState  = 32'hbb18_071e;
    repeat (3) @(posedge clk);
    #DriveDelay;
    reset = 1'b0;
    waitClock();
    testUnsigned();
    testSigned();
    testDivZero();
    testOverflow();
    testHandshake();
    $display("Summary: 5 tests, %0d with errors, %0d operations, %0d errors",
             failedTests, opCount, errCount);
    if (errCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: src/intDivUnit.sv
////////////////////////////////////////
// Restoring integer divider top level
////////////////////////////////////////
`include "intDiv_params.svh"

module intDivUnit (
  input  logic               clk,
  input  logic               reset,
  input  logic               req,
  input  divBusPkg::divReq_s reqData,
  output logic               ack,
  output divBusPkg::divRsp_s rspData
);

  import divCorePkg::*;

  logic                 start;
  logic                 iterEn;
  logic                 finishEn;
  logic                 lastStep;
  divPrepared_s         prepData;
  divPrepared_s         flags;
  logic [`DIV_XLEN-1:0] remRaw;
  logic [`DIV_XLEN-1:0] quotRaw;

  divHandshake u_divHandshake (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .lastStep(lastStep),
    .ack     (ack),
    .start   (start),
    .iterEn  (iterEn),
    .finishEn(finishEn)
  );

  // Request stays stable while req is high, so prep can stay combinational
  divOperandPrep u_divOperandPrep (
    .reqData (reqData),
    .prepData(prepData)
  );

  divIterate u_divIterate (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .iterEn  (iterEn),
    .prepData(prepData),
    .lastStep(lastStep),
    .remRaw  (remRaw),
    .quotRaw (quotRaw),
    .flags   (flags)
  );

  divResultFix u_divResultFix (
    .clk     (clk),
    .reset   (reset),
    .finishEn(finishEn),
    .remRaw  (remRaw),
    .quotRaw (quotRaw),
    .flags   (flags),
    .rspData (rspData)
  );

endmodule

// File: src/divHandshake.sv
////////////////////////////////////////
// Divider req/ack controller
// Four-phase handshake and strobe sequencing
////////////////////////////////////////
`include "intDiv_params.svh"

module divHandshake (
  input  logic clk,
  input  logic reset,
  input  logic req,
  input  logic lastStep,
  output logic ack,
  output logic start,
  output logic iterEn,
  output logic finishEn
);

  import divCorePkg::*;

  hsState_e state;
  hsState_e stateNext;

  ////////////////////////////////////////
  // State machine
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= hsIdle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      hsIdle:    if (req) stateNext = hsPrep;
      hsPrep:    stateNext = hsIterate;
      hsIterate: if (lastStep) stateNext = hsFinish;
      hsFinish:  stateNext = hsAck;
      // Hold here until the requester withdraws
      hsAck:     if (!req) stateNext = hsIdle;
      default:   stateNext = hsIdle;
    endcase
  end

  assign start    = (state == hsPrep);
  assign iterEn   = (state == hsIterate);
  assign finishEn = (state == hsFinish);

  // Ack comes one clock after the result register loads
  // and drops at the edge that sees req low
  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= (state == hsAck) && req;
    end
  end

  // Ack only answers the request that was up at the edge that started the operation
  ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req, `DIV_XLEN / `DIV_BITS_PER_CYCLE + 4))
    else $error("ack rose without the request that started the operation");

  // Iteration length depends on the counter inside the iteration core
  fixedLatency: assert property (@(posedge clk) disable iff (reset)
    start |-> ##(`DIV_XLEN / `DIV_BITS_PER_CYCLE + 1) finishEn)
    else $error("finishEn not at the fixed iteration count");

endmodule

// File: src/divResultFix.sv
////////////////////////////////////////
// Divider result fixup
// Sign correction and zero-divisor rules
////////////////////////////////////////
`include "intDiv_params.svh"

module divResultFix (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     finishEn,
  input  logic [`DIV_XLEN-1:0]     remRaw,
  input  logic [`DIV_XLEN-1:0]     quotRaw,
  input  divCorePkg::divPrepared_s flags,
  output divBusPkg::divRsp_s       rspData
);

  import divBusPkg::*;

  logic [`DIV_XLEN-1:0] quotSigned;
  logic [`DIV_XLEN-1:0] remSigned;
  logic [`DIV_XLEN-1:0] origDividend;
  logic [`DIV_XLEN-1:0] quotFinal;
  logic [`DIV_XLEN-1:0] remFinal;
  divRsp_s              rspNext;

  // Put the signs back on the unsigned results
  assign quotSigned = flags.negQuot ? -quotRaw : quotRaw;
  assign remSigned  = flags.negRem ? -remRaw : remRaw;

  // Dividend as the requester gave it, rebuilt from its magnitude
  assign origDividend = flags.negRem ? -flags.absDividend : flags.absDividend;

  // RISC-V defines x/0 as all ones and x%0 as x
  // Signed overflow needs no special case since the magnitudes already give it
  assign quotFinal = flags.divZero ? {`DIV_XLEN{1'b1}} : quotSigned;
  assign remFinal  = flags.divZero ? origDividend : remSigned;

  assign rspNext.result = flags.wantRem ? remFinal : quotFinal;

  // Result stays put until the next operation finishes
  always_ff @(posedge clk) begin
    if (reset) begin
      rspData <= '0;
    end else if (finishEn) begin
      rspData <= rspNext;
    end
  end

endmodule

// File: src/divIterate.sv
////////////////////////////////////////
// Divider iteration core
// W and XQ registers with chained steps
////////////////////////////////////////
`include "intDiv_params.svh"

module divIterate (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  logic                     iterEn,
  input  divCorePkg::divPrepared_s prepData,
  output logic                     lastStep,
  output logic [`DIV_XLEN-1:0]     remRaw,
  output logic [`DIV_XLEN-1:0]     quotRaw,
  output divCorePkg::divPrepared_s flags
);

  import divCorePkg::*;

  // Keep the counter at least one bit wide when a single step finishes the job
  localparam int CntW = (`DIV_STEPS > 1) ? $clog2(`DIV_STEPS) : 1;

  logic [`DIV_XLEN-1:0] wReg;
  logic [`DIV_XLEN-1:0] xqReg;
  divPrepared_s         flagsReg;
  logic [CntW-1:0]      stepCnt;

  // Index 0 is the register value, the last index feeds back into the registers
  logic [`DIV_XLEN-1:0] wChain  [`DIV_BITS_PER_CYCLE+1];
  logic [`DIV_XLEN-1:0] xqChain [`DIV_BITS_PER_CYCLE+1];

  ////////////////////////////////////////
  // Step chain
  ////////////////////////////////////////

  assign wChain[0]  = wReg;
  assign xqChain[0] = xqReg;

  for (genvar i = 0; i < `DIV_BITS_PER_CYCLE; i++) begin : gStep
    divStep u_divStep (
      .wIn       (wChain[i]),
      .xqIn      (xqChain[i]),
      .absDivisor(flagsReg.absDivisor),
      .wOut      (wChain[i+1]),
      .xqOut     (xqChain[i+1])
    );
  end

  ////////////////////////////////////////
  // Working registers
  ////////////////////////////////////////

  // XQ starts as the dividend and fills with quotient bits from the bottom
  always_ff @(posedge clk) begin
    if (start) begin
      wReg     <= '0;
      xqReg    <= prepData.absDividend;
      flagsReg <= prepData;
    end else if (iterEn) begin
      wReg  <= wChain[`DIV_BITS_PER_CYCLE];
      xqReg <= xqChain[`DIV_BITS_PER_CYCLE];
    end
  end

  // Step counter, cleared by each new operation
  always_ff @(posedge clk) begin
    if (reset || start) begin
      stepCnt <= '0;
    end else if (iterEn) begin
      stepCnt <= stepCnt + 1'b1;
    end
  end

  // High during the iteration clock that produces the final quotient bits
  assign lastStep = iterEn && (stepCnt == CntW'(`DIV_STEPS - 1));

  assign remRaw  = wReg;
  assign quotRaw = xqReg;
  assign flags   = flagsReg;

  // The controller must never load new operands in the middle of an iteration
  startIterExclusive: assert property (@(posedge clk) disable iff (reset)
    !(start && iterEn))
    else $error("start and iterEn asserted together");

endmodule

// File: src/divStep.sv
////////////////////////////////////////
// One restoring division step
////////////////////////////////////////
`include "intDiv_params.svh"

module divStep (
  input  logic [`DIV_XLEN-1:0] wIn,
  input  logic [`DIV_XLEN-1:0] xqIn,
  input  logic [`DIV_XLEN-1:0] absDivisor,
  output logic [`DIV_XLEN-1:0] wOut,
  output logic [`DIV_XLEN-1:0] xqOut
);

  logic [`DIV_XLEN:0]   wShift;
  logic [`DIV_XLEN+1:0] trial;
  logic                 trialNeg;

  // Partial remainder gets the next dividend bit from the top of XQ
  // It needs one extra bit since W can be as large as the divisor minus one
  assign wShift = {wIn, xqIn[`DIV_XLEN-1]};

  // Trial subtraction with a borrow bit on top
  assign trial    = {1'b0, wShift} - {2'b00, absDivisor};
  assign trialNeg = trial[`DIV_XLEN+1];

  // On success the difference is below the divisor and fits the width again
  assign wOut = trialNeg ? wShift[`DIV_XLEN-1:0] : trial[`DIV_XLEN-1:0];

  // The freed low bit of XQ takes the new quotient bit
  assign xqOut = {xqIn[`DIV_XLEN-2:0], ~trialNeg};

endmodule

// File: src/divOperandPrep.sv
////////////////////////////////////////
// Divider operand preparation
// Magnitudes, sign flags and zero divisor
////////////////////////////////////////
`include "intDiv_params.svh"

module divOperandPrep (
  input  divBusPkg::divReq_s       reqData,
  output divCorePkg::divPrepared_s prepData
);

  import divBusPkg::*;

  logic                 signedOp;
  logic                 signDividend;
  logic                 signDivisor;
  logic [`DIV_XLEN-1:0] negDividend;
  logic [`DIV_XLEN-1:0] negDivisor;

  ////////////////////////////////////////
  // Sign extraction
  ////////////////////////////////////////

  // Only DIV and REM treat their operands as two's complement
  assign signedOp = (reqData.op == opDiv) || (reqData.op == opRem);

  assign signDividend = signedOp & reqData.dividend[`DIV_XLEN-1];
  assign signDivisor  = signedOp & reqData.divisor[`DIV_XLEN-1];

  ////////////////////////////////////////
  // Magnitudes
  ////////////////////////////////////////

  assign negDividend = -reqData.dividend;
  assign negDivisor  = -reqData.divisor;

  // The most negative value negates to itself, which is its correct unsigned magnitude
  assign prepData.absDividend = signDividend ? negDividend : reqData.dividend;
  assign prepData.absDivisor  = signDivisor ? negDivisor : reqData.divisor;

  ////////////////////////////////////////
  // Result flags
  ////////////////////////////////////////

  // Quotient is negative when exactly one operand is negative
  assign prepData.negQuot = signDividend ^ signDivisor;

  // Remainder always carries the sign of the dividend
  assign prepData.negRem = signDividend;

  // A zero divisor is caught here and overridden in the fixup stage
  assign prepData.divZero = (reqData.divisor == '0);

  assign prepData.wantRem = (reqData.op == opRem) || (reqData.op == opRemu);

endmodule

// File: src/divCorePkg.sv
////////////////////////////////////////
// Divider core types
// Controller states and prepared operands
////////////////////////////////////////
`include "intDiv_params.svh"

package divCorePkg;

  // States of the four-phase req/ack controller
  typedef enum logic [2:0] {
    hsIdle,
    hsPrep,
    hsIterate,
    hsFinish,
    hsAck
  } hsState_e;

  // Unsigned magnitudes plus what the fixup stage needs to rebuild signs
  typedef struct packed {
    logic [`DIV_XLEN-1:0] absDividend;
    logic [`DIV_XLEN-1:0] absDivisor;
    logic                 negQuot;
    logic                 negRem;
    logic                 divZero;
    logic                 wantRem;
  } divPrepared_s;

endpackage

// File: src/divBusPkg.sv
////////////////////////////////////////
// Divider bus types
// Operation codes, request and response
////////////////////////////////////////
`include "intDiv_params.svh"

package divBusPkg;

  // Encoding follows the low two bits of funct3 for the M-extension divides
  typedef enum logic [1:0] {
    opDiv  = 2'b00,
    opDivu = 2'b01,
    opRem  = 2'b10,
    opRemu = 2'b11
  } divOp_e;

  // Request presented by the execute unit, held stable while req is high
  typedef struct packed {
    divOp_e              op;
    logic [`DIV_XLEN-1:0] dividend;
    logic [`DIV_XLEN-1:0] divisor;
  } divReq_s;

  // Response returned with ack
  // The result is the quotient or the remainder, as the operation asks
  typedef struct packed {
    logic [`DIV_XLEN-1:0] result;
  } divRsp_s;

endpackage

// File: src/intDiv_params.svh
////////////////////////////////////////
// Integer divider build parameters
// Data width and quotient bits per clock
////////////////////////////////////////
`ifndef INTDIV_PARAMS_SVH
`define INTDIV_PARAMS_SVH

// Operand width, fixed for RV32
`define DIV_XLEN 32

// Quotient bits resolved per clock, any power of two that divides the width
`define DIV_BITS_PER_CYCLE 2

// Number of iteration clocks per operation
`define DIV_STEPS (`DIV_XLEN / `DIV_BITS_PER_CYCLE)

`endif
